// File: source/i2c_config.svh
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// system clock and SCL rate in hertz
`define I2C_SYS_FREQ 100000000
`define I2C_BUS_FREQ 5000000

// clk cycles per quarter of one SCL period
`define I2C_QUARTER_CYCLES (`I2C_SYS_FREQ / `I2C_BUS_FREQ / 4)

// queue depths; command depth is also the initial credit grant
`define I2C_CMD_DEPTH 2
`define I2C_RSP_DEPTH 2

`endif

// File: source/i2c_pkg.sv
package i2c_pkg;

   typedef logic [6:0] dev_addr_t;
   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] byte_t;

   // quarter index inside one bit period
   typedef logic [1:0] phase_t;

   // host command word, device address in the low bits
   typedef struct packed {
      byte_t     wdata;
      reg_addr_t reg_addr;
      logic      rd;
      dev_addr_t dev_addr;
   } i2c_cmd_t;

   // one result per command
   typedef struct packed {
      byte_t rdata;
      logic  rd;
      logic  nack;
   } i2c_rsp_t;

   typedef enum logic [3:0] {
      ST_IDLE, ST_START, ST_DEV_W, ST_REG, ST_WDATA,
      ST_RESTART, ST_DEV_R, ST_RDATA, ST_STOP
   } seq_state_t;

endpackage

// File: source/i2c_cmd_queue.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_cmd_queue import i2c_pkg::*;
(
   input  logic     clk,
   input  logic     resetn,
   input  logic     cmd_valid_i,
   input  i2c_cmd_t cmd_i,
   input  logic     pop_i,
   output logic     cmd_credit_o,
   output i2c_cmd_t head_o,
   output logic     head_valid_o
);

   localparam int DEPTH = `I2C_CMD_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);

   i2c_cmd_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic [CW-1:0] owed;

   always_ff @(posedge clk)
   begin
      if (cmd_valid_i)
         mem[wr_ptr] <= cmd_i;
   end

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         // whole queue is owed to the host after reset
         owed         <= CW'(DEPTH);
         cmd_credit_o <= 1'b0;
      end
      else
      begin
         if (cmd_valid_i)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CW'(cmd_valid_i) - CW'(pop_i);
         // one pulse per cycle; a pop with nothing owed goes straight out
         cmd_credit_o <= (owed != '0) || pop_i;
         if ((owed != '0) && !pop_i)
            owed <= owed - 1'b1;
      end
   end

   assign head_o       = mem[rd_ptr];
   assign head_valid_o = (count != '0);

endmodule

// File: source/i2c_phase_gen.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_phase_gen import i2c_pkg::*;
(
   input  logic   clk,
   input  logic   resetn,
   input  logic   run_i,
   output phase_t phase_o,
   output logic   bit_end_o
);

   localparam int QC = `I2C_QUARTER_CYCLES;
   localparam int QW = $clog2(QC + 1);

   logic [QW-1:0] q_cnt;
   logic          q_last;

   // last cycle of the current quarter
   assign q_last = (q_cnt == QW'(QC - 1));

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         q_cnt   <= '0;
         phase_o <= '0;
      end
      else if (!run_i)
      begin
         // idle bus, next run starts on a fresh bit
         q_cnt   <= '0;
         phase_o <= '0;
      end
      else if (q_last)
      begin
         q_cnt   <= '0;
         phase_o <= phase_o + 1'b1;
      end
      else
         q_cnt <= q_cnt + 1'b1;
   end

   assign bit_end_o = q_last && (phase_o == 2'd3);

endmodule

// File: source/i2c_sequencer.sv
`timescale 1ns/1ps

module i2c_sequencer import i2c_pkg::*;
(
   input  logic     clk,
   input  logic     resetn,
   input  i2c_cmd_t head_i,
   input  logic     head_valid_i,
   input  logic     rsp_full_i,
   input  phase_t   phase_i,
   input  logic     bit_end_i,
   input  logic     sda_i,
   output logic     pop_o,
   output logic     run_o,
   output logic     push_o,
   output i2c_rsp_t rsp_o,
   output logic     scl_o,
   output logic     sda_o
);

   seq_state_t state;
   seq_state_t byte_next;
   i2c_cmd_t   cmd;
   byte_t      sh;
   byte_t      sh_next;
   logic [3:0] bit_cnt;
   logic       ack_slot;
   logic       smp;
   logic       smp_en;
   logic       tx_bit;
   logic       nack;
   phase_t     phase_q;

   //////////////////////////////////////////////////
   // intake and bit slot decode
   //////////////////////////////////////////////////

   // start only with a result slot guaranteed
   assign pop_o = (state == ST_IDLE) && head_valid_i && !rsp_full_i && !push_o;
   assign run_o = (state != ST_IDLE);

   // ninth slot of a byte
   assign ack_slot = (bit_cnt == 4'd8);
   // first cycle of phase 2
   assign smp_en   = (phase_i == 2'd2) && (phase_q != 2'd2);
   assign sh_next  = {sh[6:0], smp};
   // released for slave ACK and for every read slot
   assign tx_bit   = (state == ST_RDATA || ack_slot) ? 1'b1 : sh[7];

   always_comb
   begin
      case (state)
         ST_DEV_W: byte_next = ST_REG;
         ST_REG:   byte_next = cmd.rd ? ST_RESTART : ST_WDATA;
         ST_DEV_R: byte_next = ST_RDATA;
         default:  byte_next = ST_STOP;
      endcase
   end

   //////////////////////////////////////////////////
   // bus FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         state   <= ST_IDLE;
         bit_cnt <= '0;
         nack    <= 1'b0;
         push_o  <= 1'b0;
      end
      else
      begin
         push_o <= 1'b0;
         case (state)
            ST_IDLE:
               if (pop_o)
               begin
                  state   <= ST_START;
                  bit_cnt <= '0;
                  nack    <= 1'b0;
               end
            ST_START:
               if (bit_end_i)
                  state <= ST_DEV_W;
            ST_RESTART:
               if (bit_end_i)
                  state <= ST_DEV_R;
            ST_STOP:
               if (bit_end_i)
               begin
                  state  <= ST_IDLE;
                  push_o <= 1'b1;
               end
            default:
               if (bit_end_i)
               begin
                  if (!ack_slot)
                     bit_cnt <= bit_cnt + 1'b1;
                  else
                  begin
                     bit_cnt <= '0;
                     // slave NACK ends the transfer
                     if (smp && state != ST_RDATA)
                     begin
                        nack  <= 1'b1;
                        state <= ST_STOP;
                     end
                     else
                        state <= byte_next;
                  end
               end
         endcase
      end
   end

   // command, shifter and result payload
   always_ff @(posedge clk)
   begin
      if (pop_o)
         cmd <= head_i;
      if (smp_en)
         smp <= sda_i;
      if (bit_end_i)
      begin
         case (state)
            ST_START:   sh <= {cmd.dev_addr, 1'b0};
            ST_RESTART: sh <= {cmd.dev_addr, 1'b1};
            ST_DEV_W:   sh <= ack_slot ? cmd.reg_addr : sh_next;
            ST_REG:     sh <= ack_slot ? cmd.wdata : sh_next;
            ST_STOP:
               rsp_o <= '{rdata: (cmd.rd && !nack) ? sh : '0, rd: cmd.rd, nack: nack};
            default:
               if (!ack_slot)
                  sh <= sh_next;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // SCL and SDA
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         scl_o   <= 1'b1;
         sda_o   <= 1'b1;
         phase_q <= '0;
      end
      else
      begin
         phase_q <= phase_i;
         case (state)
            ST_IDLE:
            begin
               scl_o <= 1'b1;
               sda_o <= 1'b1;
            end
            // SCL held high, SDA falls halfway
            ST_START:
            begin
               scl_o <= 1'b1;
               sda_o <= ~phase_i[1];
            end
            // SDA set up while SCL low, edge one cycle after SCL rises
            ST_RESTART, ST_STOP:
            begin
               scl_o <= phase_i[1];
               if (phase_i == 2'd1)
                  sda_o <= (state == ST_RESTART);
               else if (phase_i[1] && !smp_en)
                  sda_o <= (state == ST_STOP);
            end
            default:
            begin
               scl_o <= phase_i[1];
               if (phase_i == 2'd1)
                  sda_o <= tx_bit;
            end
         endcase
      end
   end

endmodule

// File: source/i2c_rsp_queue.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_rsp_queue import i2c_pkg::*;
(
   input  logic     clk,
   input  logic     resetn,
   input  logic     push_i,
   input  i2c_rsp_t rsp_i,
   input  logic     rsp_credit_i,
   output logic     full_o,
   output logic     rsp_valid_o,
   output i2c_rsp_t rsp_o
);

   localparam int DEPTH = `I2C_RSP_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);

   i2c_rsp_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic [7:0]    credits;
   logic          send;

   // entry and credit, counting this cycle's arrivals
   assign send   = (count != '0 || push_i) && (credits != '0 || rsp_credit_i);
   assign full_o = (count == CW'(DEPTH));

   always_ff @(posedge clk)
   begin
      if (push_i)
         mem[wr_ptr] <= rsp_i;
      // empty queue passes the pushed result through
      if (send)
         rsp_o <= (count == '0) ? rsp_i : mem[rd_ptr];
   end

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         credits     <= '0;
         rsp_valid_o <= 1'b0;
      end
      else
      begin
         rsp_valid_o <= send;
         if (push_i)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (send)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count   <= count + CW'(push_i) - CW'(send);
         credits <= credits + 8'(rsp_credit_i) - 8'(send);
      end
   end

endmodule

// File: source/i2c_master.sv
`timescale 1ns/1ps

module i2c_master import i2c_pkg::*;
(
   input  logic     clk,
   input  logic     resetn,
   input  logic     cmd_valid_i,
   input  i2c_cmd_t cmd_i,
   input  logic     rsp_credit_i,
   input  logic     sda_i,
   output logic     cmd_credit_o,
   output logic     rsp_valid_o,
   output i2c_rsp_t rsp_o,
   output logic     scl_o,
   output logic     sda_o
);

   i2c_cmd_t head;
   logic     head_valid;
   logic     pop;
   logic     run;
   phase_t   phase;
   logic     bit_end;
   logic     push;
   i2c_rsp_t seq_rsp;
   logic     rsp_full;

   // host commands in, credits back
   i2c_cmd_queue i_cmd_queue (
      .clk, .resetn, .cmd_valid_i, .cmd_i, .pop_i(pop),
      .cmd_credit_o, .head_o(head), .head_valid_o(head_valid)
   );

   // bit period pacing
   i2c_phase_gen i_phase_gen (
      .clk, .resetn, .run_i(run), .phase_o(phase), .bit_end_o(bit_end)
   );

   i2c_sequencer i_sequencer (
      .clk, .resetn, .head_i(head), .head_valid_i(head_valid), .rsp_full_i(rsp_full),
      .phase_i(phase), .bit_end_i(bit_end), .sda_i, .pop_o(pop), .run_o(run),
      .push_o(push), .rsp_o(seq_rsp), .scl_o, .sda_o
   );

   // results out against host credits
   i2c_rsp_queue i_rsp_queue (
      .clk, .resetn, .push_i(push), .rsp_i(seq_rsp), .rsp_credit_i,
      .full_o(rsp_full), .rsp_valid_o, .rsp_o
   );

endmodule

// File: sim/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model import i2c_pkg::*;
#(
   parameter dev_addr_t DEV_ADDR = 7'h1B
)
(
   input  logic clk,
   input  logic resetn,
   input  logic scl_i,
   input  logic sda_i,
   output logic sda_o
);

   byte_t      regs [256];
   byte_t      rx;
   byte_t      tx;
   reg_addr_t  ptr;
   logic [3:0] bit_cnt;
   logic [2:0] byte_cnt;
   logic       scl_q;
   logic       sda_q;
   logic       in_frame;
   logic       sel;
   logic       rd_mode;
   logic       scl_rise;
   logic       scl_fall;
   logic       start_det;
   logic       stop_det;

   // lines oversampled on the falling clk edge
   assign scl_rise  = scl_i && !scl_q;
   assign scl_fall  = !scl_i && scl_q;
   // SDA edges while SCL stays high
   assign start_det = scl_i && scl_q && sda_q && !sda_i;
   assign stop_det  = scl_i && scl_q && !sda_q && sda_i;

   always @(negedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         scl_q    <= 1'b1;
         sda_q    <= 1'b1;
         sda_o    <= 1'b1;
         in_frame <= 1'b0;
         sel      <= 1'b0;
         rd_mode  <= 1'b0;
         bit_cnt  <= '0;
         byte_cnt <= '0;
      end
      else
      begin
         scl_q <= scl_i;
         sda_q <= sda_i;
         // start and repeated start both begin a new address byte
         if (start_det)
         begin
            in_frame <= 1'b1;
            sel      <= 1'b0;
            rd_mode  <= 1'b0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            sda_o    <= 1'b1;
         end
         else if (stop_det)
         begin
            in_frame <= 1'b0;
            sel      <= 1'b0;
            sda_o    <= 1'b1;
         end
         else if (in_frame && scl_rise && bit_cnt < 4'd8)
         begin
            rx      <= {rx[6:0], sda_i};
            bit_cnt <= bit_cnt + 1'b1;
         end
         else if (in_frame && scl_fall)
         begin
            if (bit_cnt == 4'd8)
            begin
               // byte complete, ninth slot follows
               bit_cnt <= 4'd9;
               if (byte_cnt == 3'd0)
               begin
                  sel     <= (rx[7:1] == DEV_ADDR);
                  rd_mode <= rx[0];
                  sda_o   <= (rx[7:1] != DEV_ADDR);
                  tx      <= regs[ptr];
               end
               else if (sel && !rd_mode)
               begin
                  // register pointer first, then write data
                  if (byte_cnt == 3'd1)
                     ptr <= rx;
                  else
                     regs[ptr] <= rx;
                  sda_o <= 1'b0;
               end
               else
                  sda_o <= 1'b1;
            end
            else if (bit_cnt == 4'd9)
            begin
               bit_cnt  <= '0;
               byte_cnt <= byte_cnt + 1'b1;
               if (sel && rd_mode && byte_cnt == 3'd0)
               begin
                  sda_o <= tx[7];
                  tx    <= {tx[6:0], 1'b1};
               end
               else
               begin
                  sda_o <= 1'b1;
                  // single byte reads only
                  if (rd_mode)
                     sel <= 1'b0;
               end
            end
            else if (sel && rd_mode && byte_cnt != 3'd0)
            begin
               sda_o <= tx[7];
               tx    <= {tx[6:0], 1'b1};
            end
         end
      end
   end

endmodule

// File: sim/tb_i2c_master.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module tb_i2c_master import i2c_pkg::*;
();

   localparam int        CLK_PERIOD  = 8;
   localparam int        BIT_CYCLES  = 4 * `I2C_QUARTER_CYCLES;
   localparam dev_addr_t SLAVE_ADDR  = 7'h1B;
   localparam dev_addr_t BAD_ADDR    = 7'h2A;
   // bus transactions issued over all tests
   localparam int        NUM_XFERS   = 18;
   // quiet window of the back-pressure test in clk cycles
   localparam int        HOLD_CYCLES = 4 * 40 * BIT_CYCLES;
   localparam int        WATCHDOG_NS =
      (NUM_XFERS * 40 * BIT_CYCLES + HOLD_CYCLES) * CLK_PERIOD * 2;

   logic     clk;
   logic     resetn;
   logic     cmd_valid;
   i2c_cmd_t cmd;
   logic     rsp_credit;
   logic     cmd_credit;
   logic     rsp_valid;
   i2c_rsp_t rsp;
   logic     scl;
   logic     dut_sda;
   logic     slave_sda;
   logic     sda_bus;

   i2c_rsp_t rsp_q [$];
   int       credit_total;
   int       cmd_sent;
   int       rsp_total;
   int       errors;
   int       tests_run;
   int       tests_failed;

   i2c_master i_dut (
      .clk, .resetn, .cmd_valid_i(cmd_valid), .cmd_i(cmd), .rsp_credit_i(rsp_credit),
      .sda_i(sda_bus), .cmd_credit_o(cmd_credit), .rsp_valid_o(rsp_valid), .rsp_o(rsp),
      .scl_o(scl), .sda_o(dut_sda)
   );

   i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) i_slave (
      .clk, .resetn, .scl_i(scl), .sda_i(sda_bus), .sda_o(slave_sda)
   );

   // open-drain wired-AND
   assign sda_bus = dut_sda & slave_sda;

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////
   // host side monitors and helpers
   //////////////////////////////////////////////////

   // outputs settle after the rising edge so collect on the falling one
   always @(negedge clk)
   begin
      if (resetn)
      begin
         if (cmd_credit)
            credit_total++;
         if (rsp_valid)
         begin
            rsp_q.push_back(rsp);
            rsp_total++;
         end
      end
   end

   function automatic i2c_rsp_t make_rsp(input byte_t rdata, input logic rd, input logic nack);
      i2c_rsp_t r;
      r.rdata = rdata;
      r.rd    = rd;
      r.nack  = nack;
      return r;
   endfunction

   // spends one command credit and waits while none is held
   task automatic send_cmd(input dev_addr_t dev, input logic rd, input reg_addr_t ra,
                           input byte_t wd);
      i2c_cmd_t c;
      c.wdata    = wd;
      c.reg_addr = ra;
      c.rd       = rd;
      c.dev_addr = dev;
      @(posedge clk);
      while (credit_total == cmd_sent)
         @(posedge clk);
      cmd       <= c;
      cmd_valid <= 1'b1;
      cmd_sent++;
      @(posedge clk);
      cmd_valid <= 1'b0;
   endtask

   // one credit per cycle of the pulse
   task automatic grant_rsp_credits(input int n);
      @(posedge clk);
      rsp_credit <= 1'b1;
      repeat (n) @(posedge clk);
      rsp_credit <= 1'b0;
   endtask

   task automatic expect_rsp(input string name, input i2c_rsp_t exp);
      i2c_rsp_t act;
      while (rsp_q.size() == 0)
         @(posedge clk);
      act = rsp_q.pop_front();
      if (act !== exp)
      begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp)
      begin
         $display("error %s: expected %0h, actual %0h", name, exp, act);
         errors++;
      end
   endtask

   task automatic close_test(input string name, input int errors_before);
      tests_run++;
      if (errors != errors_before)
      begin
         tests_failed++;
         $display("test %s: failed", name);
      end
      else
         $display("test %s: passed", name);
   endtask

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic after_reset_idle();
      int start;
      int bad;
      start = errors;
      bad   = 0;
      // long enough for the whole initial credit grant
      repeat (4 * BIT_CYCLES)
      begin
         @(negedge clk);
         if (scl !== 1'b1 || dut_sda !== 1'b1 || rsp_valid !== 1'b0)
            bad++;
      end
      if (bad != 0)
      begin
         $display("error after_reset: bus not released or a result sent while idle");
         errors++;
      end
      check_value("after_reset credits", `I2C_CMD_DEPTH, credit_total);
      check_value("after_reset results", 0, rsp_total);
      close_test("after_reset", start);
   endtask

   task automatic write_then_read();
      int    start;
      byte_t data;
      start = errors;
      data  = 8'($urandom);
      grant_rsp_credits(2);
      send_cmd(SLAVE_ADDR, 1'b0, 8'h10, data);
      expect_rsp("write_read write", make_rsp(8'h00, 1'b0, 1'b0));
      send_cmd(SLAVE_ADDR, 1'b1, 8'h10, 8'h00);
      expect_rsp("write_read read", make_rsp(data, 1'b1, 1'b0));
      check_value("write_read slave register", 32'(data), 32'(i_slave.regs[8'h10]));
      close_test("write_read", start);
   endtask

   task automatic multi_register();
      int        start;
      reg_addr_t addrs [4];
      byte_t     vals [4];
      int        order [4];
      start = errors;
      addrs = '{8'h21, 8'h42, 8'h63, 8'h84};
      order = '{2, 0, 3, 1};
      // credits up front so results never stall the bus
      grant_rsp_credits(8);
      for (int i = 0; i < 4; i++)
      begin
         vals[i] = 8'($urandom);
         send_cmd(SLAVE_ADDR, 1'b0, addrs[i], vals[i]);
      end
      for (int i = 0; i < 4; i++)
         send_cmd(SLAVE_ADDR, 1'b1, addrs[order[i]], 8'h00);
      for (int i = 0; i < 4; i++)
         expect_rsp("multi_reg write", make_rsp(8'h00, 1'b0, 1'b0));
      for (int i = 0; i < 4; i++)
         expect_rsp("multi_reg read", make_rsp(vals[order[i]], 1'b1, 1'b0));
      close_test("multi_reg", start);
   endtask

   task automatic wrong_address();
      int    start;
      byte_t data;
      start = errors;
      data  = 8'($urandom);
      grant_rsp_credits(2);
      send_cmd(BAD_ADDR, 1'b1, 8'h10, 8'h00);
      expect_rsp("bad_addr read", make_rsp(8'h00, 1'b1, 1'b1));
      // bus must be free again for the right slave
      send_cmd(SLAVE_ADDR, 1'b0, 8'h35, data);
      expect_rsp("bad_addr recovery", make_rsp(8'h00, 1'b0, 1'b0));
      check_value("bad_addr slave register", 32'(data), 32'(i_slave.regs[8'h35]));
      close_test("bad_addr", start);
   endtask

   task automatic result_backpressure();
      int    start;
      int    base;
      byte_t data;
      start = errors;
      base  = rsp_total;
      data  = 8'($urandom);
      send_cmd(SLAVE_ADDR, 1'b0, 8'h4C, data);
      send_cmd(SLAVE_ADDR, 1'b1, 8'h4C, 8'h00);
      repeat (HOLD_CYCLES) @(negedge clk);
      if (rsp_total != base)
      begin
         $display("error backpressure: a result was sent without a credit");
         errors++;
      end
      if (scl !== 1'b1 || dut_sda !== 1'b1)
      begin
         $display("error backpressure: bus not released while results wait");
         errors++;
      end
      grant_rsp_credits(1);
      expect_rsp("backpressure first", make_rsp(8'h00, 1'b0, 1'b0));
      repeat (BIT_CYCLES) @(negedge clk);
      check_value("backpressure results after one credit", base + 1, rsp_total);
      grant_rsp_credits(1);
      expect_rsp("backpressure second", make_rsp(data, 1'b1, 1'b0));
      close_test("backpressure", start);
   endtask

   task automatic command_credits();
      int    start;
      byte_t d0;
      byte_t d1;
      start = errors;
      d0    = 8'($urandom);
      d1    = 8'($urandom);
      // result credits held back until all four are in
      // so the result queue fills and later commands wait for it
      send_cmd(SLAVE_ADDR, 1'b0, 8'h5A, d0);
      send_cmd(SLAVE_ADDR, 1'b0, 8'h5B, d1);
      send_cmd(SLAVE_ADDR, 1'b1, 8'h5B, 8'h00);
      send_cmd(SLAVE_ADDR, 1'b1, 8'h5A, 8'h00);
      grant_rsp_credits(4);
      expect_rsp("cmd_credits write 0", make_rsp(8'h00, 1'b0, 1'b0));
      expect_rsp("cmd_credits write 1", make_rsp(8'h00, 1'b0, 1'b0));
      expect_rsp("cmd_credits read 1", make_rsp(d1, 1'b1, 1'b0));
      expect_rsp("cmd_credits read 0", make_rsp(d0, 1'b1, 1'b0));
      // every pop has long since returned its credit
      check_value("cmd_credits returned", cmd_sent + `I2C_CMD_DEPTH, credit_total);
      close_test("cmd_credits", start);
   endtask

   //////////////////////////////////////////////////
   // run control
   //////////////////////////////////////////////////

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      void'($urandom(32'h3141d0bf));
      resetn       = 1'b0;
      cmd_valid    = 1'b0;
      cmd          = '0;
      rsp_credit   = 1'b0;
      credit_total = 0;
      cmd_sent     = 0;
      rsp_total    = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (2) @(posedge clk);
      resetn <= 1'b1;
      after_reset_idle();
      write_then_read();
      multi_register();
      wrong_address();
      result_backpressure();
      command_credits();
      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: i2c_master.f
+incdir+source
source/i2c_pkg.sv
source/i2c_cmd_queue.sv
source/i2c_phase_gen.sv
source/i2c_sequencer.sv
source/i2c_rsp_queue.sv
source/i2c_master.sv
sim/i2c_slave_model.sv
sim/tb_i2c_master.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing
SIM_FLAGS = --binary -j 0
TOP       = tb_i2c_master
RTL_TOP   = i2c_master
FILELIST  = i2c_master.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== PASS ===" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
